// ==== hw/exu_pkg.sv ====
package exu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  alu_ctrl_t;
    typedef logic [2:0]  br_ctrl_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // alu operation codes
    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_AND  = 4'd2;
    localparam alu_ctrl_t ALU_OR   = 4'd3;
    localparam alu_ctrl_t ALU_XOR  = 4'd4;
    localparam alu_ctrl_t ALU_SLT  = 4'd5;
    localparam alu_ctrl_t ALU_SLTU = 4'd6;
    localparam alu_ctrl_t ALU_SRL  = 4'd7;
    localparam alu_ctrl_t ALU_SLL  = 4'd8;
    localparam alu_ctrl_t ALU_NONE = 4'd15;

    // branch conditions
    localparam br_ctrl_t BR_EQ   = 3'd0;
    localparam br_ctrl_t BR_NE   = 3'd1;
    localparam br_ctrl_t BR_LT   = 3'd2;
    localparam br_ctrl_t BR_GE   = 3'd3;
    localparam br_ctrl_t BR_LTU  = 3'd4;
    localparam br_ctrl_t BR_GEU  = 3'd5;
    localparam br_ctrl_t BR_NONE = 3'd7;

    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // funct3 for OP_R and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL     = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 for OP_BRANCH
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DONE
    } ctrl_state_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu #(
    parameter int DATA_WIDTH  = 32,
    parameter int SHIFT_WIDTH = 5
) (
    input  logic [DATA_WIDTH-1:0]  SrcA_i,
    input  logic [DATA_WIDTH-1:0]  SrcB_i,
    input  exu_pkg::alu_ctrl_t     ALUctrl_i,
    input  exu_pkg::br_ctrl_t      BranchCtrl_i,
    input  logic [SHIFT_WIDTH-1:0] shift,

    output logic [DATA_WIDTH-1:0]  ALUResult_o,
    output logic                   branch_operation_o
);

    logic equal;
    logic lt_unsigned;
    logic lt_signed;
    logic sign_a;
    logic sign_b;

    assign sign_a = SrcA_i[DATA_WIDTH-1];
    assign sign_b = SrcB_i[DATA_WIDTH-1];

    assign equal       = (SrcA_i == SrcB_i);
    assign lt_unsigned = (SrcA_i < SrcB_i);

    // differing signs: the negative one is smaller
    // same sign: unsigned order holds for two's complement
    assign lt_signed = (sign_a != sign_b) ? sign_a : lt_unsigned;

    // branch comparator
    always_comb begin
        case (BranchCtrl_i)
            exu_pkg::BR_EQ:  branch_operation_o = equal;
            exu_pkg::BR_NE:  branch_operation_o = !equal;
            exu_pkg::BR_LT:  branch_operation_o = lt_signed;
            exu_pkg::BR_GE:  branch_operation_o = !lt_signed;
            exu_pkg::BR_LTU: branch_operation_o = lt_unsigned;
            exu_pkg::BR_GEU: branch_operation_o = !lt_unsigned;
            default:         branch_operation_o = 1'b0;
        endcase
    end

    always_comb begin
        case (ALUctrl_i)
            exu_pkg::ALU_ADD: begin
                ALUResult_o = SrcA_i + SrcB_i;
            end

            exu_pkg::ALU_SUB: begin
                ALUResult_o = SrcA_i - SrcB_i;
            end

            exu_pkg::ALU_AND: begin
                ALUResult_o = SrcA_i & SrcB_i;
            end

            exu_pkg::ALU_OR: begin
                ALUResult_o = SrcA_i | SrcB_i;
            end

            exu_pkg::ALU_XOR: begin
                ALUResult_o = SrcA_i ^ SrcB_i;
            end

            // set-less-than gives 0 or 1
            exu_pkg::ALU_SLT: begin
                ALUResult_o = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            end

            exu_pkg::ALU_SLTU: begin
                ALUResult_o = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            end

            // logical shifts only
            exu_pkg::ALU_SRL: begin
                ALUResult_o = SrcA_i >> shift;
            end

            exu_pkg::ALU_SLL: begin
                ALUResult_o = SrcA_i << shift;
            end

            default: begin
                ALUResult_o = '0;
            end
        endcase
    end

endmodule

// ==== hw/branch_target.sv ====
`timescale 1ns/100ps

module branch_target #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] pc_i,
    input  logic [DATA_WIDTH-1:0] imm_b_i,
    input  logic                  is_branch_i,
    input  logic                  taken_i,
    output logic [DATA_WIDTH-1:0] next_pc_o
);

    logic [DATA_WIDTH-1:0] pc_plus4;
    logic [DATA_WIDTH-1:0] pc_target;
    logic                  take_target;

    // sequential successor
    assign pc_plus4 = pc_i + DATA_WIDTH'(4);

    // imm_b_i is already sign-extended, so negative offsets wrap correctly
    assign pc_target = pc_i + imm_b_i;

    assign take_target = is_branch_i && taken_i;

    assign next_pc_o = take_target ? pc_target : pc_plus4;

endmodule

// ==== hw/exu_decoder.sv ====
`timescale 1ns/100ps

module exu_decoder (
    input  exu_pkg::instr_t    instr_i,
    input  exu_pkg::word_t     rs2_i,
    output exu_pkg::alu_ctrl_t alu_ctrl_o,
    output exu_pkg::br_ctrl_t  br_ctrl_o,
    output exu_pkg::word_t     src_b_o,
    output exu_pkg::shamt_t    shamt_o,
    output exu_pkg::word_t     imm_b_o,
    output logic               is_branch_o,
    output logic               illegal_o
);

    exu_pkg::opcode_t opcode;
    exu_pkg::funct3_t funct3;
    exu_pkg::funct7_t funct7;
    exu_pkg::word_t   imm_i;
    logic             bad_enc;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};

    // B-type immediate, bit 0 always zero
    assign imm_b_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        alu_ctrl_o  = exu_pkg::ALU_NONE;
        br_ctrl_o   = exu_pkg::BR_NONE;
        src_b_o     = rs2_i;
        shamt_o     = '0;
        is_branch_o = 1'b0;
        bad_enc     = 1'b0;

        case (opcode)
            exu_pkg::OP_R: begin
                // register shifts use only the low 5 bits
                shamt_o = rs2_i[4:0];
                case (funct3)
                    exu_pkg::F3_ADD_SUB: begin
                        if (funct7 == exu_pkg::F7_ALT) begin
                            alu_ctrl_o = exu_pkg::ALU_SUB;
                        end else begin
                            alu_ctrl_o = exu_pkg::ALU_ADD;
                        end
                    end
                    exu_pkg::F3_SLL:  alu_ctrl_o = exu_pkg::ALU_SLL;
                    exu_pkg::F3_SLT:  alu_ctrl_o = exu_pkg::ALU_SLT;
                    exu_pkg::F3_SLTU: alu_ctrl_o = exu_pkg::ALU_SLTU;
                    exu_pkg::F3_XOR:  alu_ctrl_o = exu_pkg::ALU_XOR;
                    exu_pkg::F3_SRL:  alu_ctrl_o = exu_pkg::ALU_SRL;
                    exu_pkg::F3_OR:   alu_ctrl_o = exu_pkg::ALU_OR;
                    exu_pkg::F3_AND:  alu_ctrl_o = exu_pkg::ALU_AND;
                    default:          bad_enc = 1'b1;
                endcase
                // only sub may use the alternate funct7, so sra is rejected
                if (!((funct7 == exu_pkg::F7_BASE) ||
                      (funct7 == exu_pkg::F7_ALT && funct3 == exu_pkg::F3_ADD_SUB))) begin
                    bad_enc = 1'b1;
                end
            end

            exu_pkg::OP_IMM: begin
                src_b_o = imm_i;
                shamt_o = instr_i[24:20];
                case (funct3)
                    exu_pkg::F3_ADD_SUB: alu_ctrl_o = exu_pkg::ALU_ADD;
                    exu_pkg::F3_SLL:     alu_ctrl_o = exu_pkg::ALU_SLL;
                    exu_pkg::F3_SLT:     alu_ctrl_o = exu_pkg::ALU_SLT;
                    exu_pkg::F3_SLTU:    alu_ctrl_o = exu_pkg::ALU_SLTU;
                    exu_pkg::F3_XOR:     alu_ctrl_o = exu_pkg::ALU_XOR;
                    exu_pkg::F3_SRL:     alu_ctrl_o = exu_pkg::ALU_SRL;
                    exu_pkg::F3_OR:      alu_ctrl_o = exu_pkg::ALU_OR;
                    exu_pkg::F3_AND:     alu_ctrl_o = exu_pkg::ALU_AND;
                    default:             bad_enc = 1'b1;
                endcase
                // slli/srli need a zero funct7, srai is not supported
                if ((funct3 == exu_pkg::F3_SLL || funct3 == exu_pkg::F3_SRL) &&
                    funct7 != exu_pkg::F7_BASE) begin
                    bad_enc = 1'b1;
                end
            end

            exu_pkg::OP_BRANCH: begin
                is_branch_o = 1'b1;
                case (funct3)
                    exu_pkg::F3_BEQ:  br_ctrl_o = exu_pkg::BR_EQ;
                    exu_pkg::F3_BNE:  br_ctrl_o = exu_pkg::BR_NE;
                    exu_pkg::F3_BLT:  br_ctrl_o = exu_pkg::BR_LT;
                    exu_pkg::F3_BGE:  br_ctrl_o = exu_pkg::BR_GE;
                    exu_pkg::F3_BLTU: br_ctrl_o = exu_pkg::BR_LTU;
                    exu_pkg::F3_BGEU: br_ctrl_o = exu_pkg::BR_GEU;
                    default:          bad_enc = 1'b1;
                endcase
            end

            default: bad_enc = 1'b1;
        endcase

        // illegal encodings give a zero result and a not-taken branch
        if (bad_enc) begin
            alu_ctrl_o  = exu_pkg::ALU_NONE;
            br_ctrl_o   = exu_pkg::BR_NONE;
            is_branch_o = 1'b0;
        end
    end

    assign illegal_o = bad_enc;

endmodule

// ==== hw/exu_ctrl.sv ====
`timescale 1ns/100ps

module exu_ctrl (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_i,
    input  exu_pkg::instr_t instr_i,
    input  exu_pkg::word_t  pc_i,
    input  exu_pkg::word_t  rs1_i,
    input  exu_pkg::word_t  rs2_i,

    output exu_pkg::instr_t instr_q_o,
    output exu_pkg::word_t  pc_q_o,
    output exu_pkg::word_t  rs1_q_o,
    output exu_pkg::word_t  rs2_q_o,

    input  exu_pkg::word_t  alu_result_i,
    input  logic            branch_op_i,
    input  exu_pkg::word_t  next_pc_i,
    input  logic            illegal_i,

    output logic            ack_o,
    output exu_pkg::word_t  result_o,
    output logic            taken_o,
    output exu_pkg::word_t  next_pc_o,
    output logic            illegal_o
);

    exu_pkg::ctrl_state_t state_q;
    exu_pkg::ctrl_state_t state_d;
    logic                 capture;
    logic                 load_result;

    assign capture     = (state_q == exu_pkg::IDLE) && req_i;
    assign load_result = (state_q == exu_pkg::EXEC);

    always_comb begin
        state_d = state_q;
        case (state_q)
            exu_pkg::IDLE: begin
                if (req_i) begin
                    state_d = exu_pkg::EXEC;
                end
            end
            // datapath settles within this cycle
            exu_pkg::EXEC: begin
                state_d = exu_pkg::DONE;
            end
            // hold until the requester drops req
            exu_pkg::DONE: begin
                if (!req_i) begin
                    state_d = exu_pkg::IDLE;
                end
            end
            default: begin
                state_d = exu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= exu_pkg::IDLE;
            ack_o     <= 1'b0;
            result_o  <= '0;
            taken_o   <= 1'b0;
            next_pc_o <= '0;
            illegal_o <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_o   <= (state_d == exu_pkg::DONE);
            if (load_result) begin
                result_o  <= alu_result_i;
                taken_o   <= branch_op_i;
                next_pc_o <= next_pc_i;
                illegal_o <= illegal_i;
            end
        end
    end

    // operand capture
    always_ff @(posedge clk_i) begin
        if (capture) begin
            instr_q_o <= instr_i;
            pc_q_o    <= pc_i;
            rs1_q_o   <= rs1_i;
            rs2_q_o   <= rs2_i;
        end
    end

endmodule

// ==== hw/exu_top.sv ====
`timescale 1ns/100ps

module exu_top #(
    parameter int DATA_WIDTH  = 32,
    parameter int SHIFT_WIDTH = 5
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_i,
    input  exu_pkg::instr_t instr_i,
    input  exu_pkg::word_t  pc_i,
    input  exu_pkg::word_t  rs1_i,
    input  exu_pkg::word_t  rs2_i,

    output logic            ack_o,
    output exu_pkg::word_t  result_o,
    output logic            taken_o,
    output exu_pkg::word_t  next_pc_o,
    output logic            illegal_o
);

    // captured operands
    exu_pkg::instr_t instr_q;
    exu_pkg::word_t  pc_q;
    exu_pkg::word_t  rs1_q;
    exu_pkg::word_t  rs2_q;

    // decode
    exu_pkg::alu_ctrl_t alu_ctrl;
    exu_pkg::br_ctrl_t  br_ctrl;
    exu_pkg::word_t     src_b;
    exu_pkg::shamt_t    shamt;
    exu_pkg::word_t     imm_b;
    logic               is_branch;
    logic               dec_illegal;

    // datapath results
    exu_pkg::word_t alu_result;
    logic           branch_op;
    exu_pkg::word_t next_pc;

    exu_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .instr_q_o    (instr_q),
        .pc_q_o       (pc_q),
        .rs1_q_o      (rs1_q),
        .rs2_q_o      (rs2_q),
        .alu_result_i (alu_result),
        .branch_op_i  (branch_op),
        .next_pc_i    (next_pc),
        .illegal_i    (dec_illegal),
        .ack_o        (ack_o),
        .result_o     (result_o),
        .taken_o      (taken_o),
        .next_pc_o    (next_pc_o),
        .illegal_o    (illegal_o)
    );

    exu_decoder u_decoder (
        .instr_i     (instr_q),
        .rs2_i       (rs2_q),
        .alu_ctrl_o  (alu_ctrl),
        .br_ctrl_o   (br_ctrl),
        .src_b_o     (src_b),
        .shamt_o     (shamt),
        .imm_b_o     (imm_b),
        .is_branch_o (is_branch),
        .illegal_o   (dec_illegal)
    );

    alu #(
        .DATA_WIDTH  (DATA_WIDTH),
        .SHIFT_WIDTH (SHIFT_WIDTH)
    ) u_alu (
        .SrcA_i             (rs1_q),
        .SrcB_i             (src_b),
        .ALUctrl_i          (alu_ctrl),
        .BranchCtrl_i       (br_ctrl),
        .shift              (shamt),
        .ALUResult_o        (alu_result),
        .branch_operation_o (branch_op)
    );

    branch_target #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_branch_target (
        .pc_i        (pc_q),
        .imm_b_i     (imm_b),
        .is_branch_i (is_branch),
        .taken_i     (branch_op),
        .next_pc_o   (next_pc)
    );

endmodule

// ==== sim/exu_sva.sv ====
`timescale 1ns/100ps

module exu_sva (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 req_i,
    input logic                 ack_i,
    input exu_pkg::word_t       result_i,
    input logic                 taken_i,
    input exu_pkg::word_t       next_pc_i,
    input logic                 illegal_i,
    input exu_pkg::ctrl_state_t state_i
);

    // reset keeps the handshake idle
    reset_idle: assert property (@(posedge clk_i)
        !rst_n_i |-> !ack_i && state_i == exu_pkg::IDLE)
        else $error("ack high or state not IDLE during reset");

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i)
        else $error("ack rose while req was low");

    // results frozen for as long as ack stays up
    outputs_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i && $past(ack_i) |-> $stable(result_i) && $stable(taken_i) &&
        $stable(next_pc_i) && $stable(illegal_i))
        else $error("outputs changed while ack was high");

endmodule

bind exu_ctrl exu_sva u_exu_sva (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .ack_i     (ack_o),
    .result_i  (result_o),
    .taken_i   (taken_o),
    .next_pc_i (next_pc_o),
    .illegal_i (illegal_o),
    .state_i   (state_q)
);

// ==== sim/tb_exu_top.sv ====
`timescale 1ns/100ps

module tb_exu_top;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int NAME_BITS      = 8 * 32;
    localparam int LINE_BITS      = 8 * 200;

    logic            clk_i;
    logic            rst_n_i;
    logic            req_i;
    exu_pkg::instr_t instr_i;
    exu_pkg::word_t  pc_i;
    exu_pkg::word_t  rs1_i;
    exu_pkg::word_t  rs2_i;
    logic            ack_o;
    exu_pkg::word_t  result_o;
    logic            taken_o;
    exu_pkg::word_t  next_pc_o;
    logic            illegal_o;

    int seed;
    int tests;
    int failed_tests;
    int setup_errors;
    int test_errors;

    exu_top exu_top_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .instr_i   (instr_i),
        .pc_i      (pc_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .ack_o     (ack_o),
        .result_o  (result_o),
        .taken_o   (taken_o),
        .next_pc_o (next_pc_o),
        .illegal_o (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // idle gap and req hold time, 0 to 3 cycles
    function automatic int pick_delay();
        pick_delay = int'($unsigned($random(seed)) % 4);
    endfunction

    task automatic check_value(input logic [NAME_BITS-1:0] name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %0s %0s expected %h actual %h", name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic run_vector(input logic [NAME_BITS-1:0] name, input exu_pkg::instr_t instr,
                              input exu_pkg::word_t pc, input exu_pkg::word_t rs1,
                              input exu_pkg::word_t rs2, input exu_pkg::word_t exp_result,
                              input logic exp_taken, input exu_pkg::word_t exp_next_pc,
                              input logic exp_illegal);
        int             edges;
        int             hold;
        exu_pkg::word_t held_result;
        exu_pkg::word_t held_next_pc;
        logic           held_taken;
        logic           held_illegal;

        test_errors = 0;
        repeat (pick_delay()) @(posedge clk_i);
        @(posedge clk_i);
        req_i   <= 1'b1;
        instr_i <= instr;
        pc_i    <= pc;
        rs1_i   <= rs1;
        rs2_i   <= rs2;

        // count rising edges until ack is seen
        edges = 0;
        while (ack_o !== 1'b1 && edges < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end

        if (ack_o !== 1'b1) begin
            $display("Timeout: ack did not rise within %0d cycles in %0s", TIMEOUT_CYCLES, name);
            test_errors++;
        end else begin
            assert (edges == 2) else begin
                $display("Mismatch %0s latency expected 2 actual %0d", name, edges);
                test_errors++;
            end
            check_value(name, "result", exp_result, result_o);
            check_value(name, "taken", {31'b0, exp_taken}, {31'b0, taken_o});
            check_value(name, "next_pc", exp_next_pc, next_pc_o);
            check_value(name, "illegal", {31'b0, exp_illegal}, {31'b0, illegal_o});

            held_result  = result_o;
            held_taken   = taken_o;
            held_next_pc = next_pc_o;
            held_illegal = illegal_o;
            hold = pick_delay();
            // back-pressure, outputs must not move
            repeat (hold) begin
                @(negedge clk_i);
                assert (ack_o === 1'b1 && result_o === held_result && taken_o === held_taken &&
                        next_pc_o === held_next_pc && illegal_o === held_illegal) else begin
                    $display("Outputs or ack changed while req was held high in %0s", name);
                    test_errors++;
                end
            end
        end

        @(posedge clk_i);
        req_i <= 1'b0;
        edges = 0;
        while (ack_o !== 1'b0 && edges < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end
        if (ack_o !== 1'b0) begin
            $display("Timeout: ack did not fall within %0d cycles in %0s", TIMEOUT_CYCLES, name);
            test_errors++;
        end

        tests++;
        if (test_errors == 0) begin
            $display("ok    %0s", name);
        end else begin
            $display("bad   %0s (%0d errors)", name, test_errors);
            failed_tests++;
        end
    endtask

    initial begin
        int                   fd;
        int                   code;
        int                   fields;
        logic [LINE_BITS-1:0] line;
        logic [NAME_BITS-1:0] name;
        logic [31:0]          instr;
        logic [31:0]          pc;
        logic [31:0]          rs1;
        logic [31:0]          rs2;
        logic [31:0]          res;
        logic [31:0]          tkn;
        logic [31:0]          nxt;
        logic [31:0]          ill;

        seed         = 32'h29114db1;
        tests        = 0;
        failed_tests = 0;
        setup_errors = 0;
        test_errors  = 0;
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        instr_i      = '0;
        pc_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        fd = $fopen("sim/exu_stim.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the stimulus file sim/exu_stim.txt");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                // comment and blank lines do not yield all nine fields
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                                 name, instr, pc, rs1, rs2, res, tkn, nxt, ill);
                if (code > 0 && fields == 9) begin
                    run_vector(name, instr, pc, rs1, rs2, res, tkn[0], nxt, ill[0]);
                end
            end
            $fclose(fd);
        end

        if (tests == 0) begin
            $display("Error: no test vectors were run");
            setup_errors++;
        end
        $display("tests %0d, passed %0d, failed %0d", tests, tests - failed_tests, failed_tests);
        if (failed_tests == 0 && setup_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim/exu_stim.txt ====
# vector name, instr, pc, rs1, rs2 in hex
# then expected result, taken, next_pc, illegal in hex
add_basic      002081b3 00001000 00000005 00000007 0000000c 0 00001004 0
add_wrap       002081b3 00001004 ffffffff 00000002 00000001 0 00001008 0
sub_basic      402081b3 00001008 00000010 00000003 0000000d 0 0000100c 0
sub_wrap       402081b3 0000100c 00000000 00000001 ffffffff 0 00001010 0
and_reg        0020f1b3 00001010 f0f0ff00 0ff0f0f0 00f0f000 0 00001014 0
or_reg         0020e1b3 00001014 f0f0ff00 0ff0f0f0 fff0fff0 0 00001018 0
xor_reg        0020c1b3 00001018 f0f0ff00 0ff0f0f0 ff000ff0 0 0000101c 0
addi_pos       06408193 00001020 00000010 deadbeef 00000074 0 00001024 0
addi_neg       ffb08193 00001024 00000003 00000000 fffffffe 0 00001028 0
andi_mask      0f00f193 00001028 12345678 00000000 00000070 0 0000102c 0
ori_imm        7000e193 0000102c 00000012 00000000 00000712 0 00001030 0
xori_invert    fff0c193 00001030 0000ffff 00000000 ffff0000 0 00001034 0
slt_mixed      0020a1b3 00002000 ffffffff 00000001 00000001 0 00002004 0
sltu_mixed     0020b1b3 00002004 ffffffff 00000001 00000000 0 00002008 0
slt_same_neg   0020a1b3 00002008 fffffff0 ffffffff 00000001 0 0000200c 0
slt_equal      0020a1b3 0000200c 00000007 00000007 00000000 0 00002010 0
sltu_same      0020b1b3 00002010 00000003 00000009 00000001 0 00002014 0
slti_neg       fff0a193 00002014 fffffffd 00000000 00000001 0 00002018 0
slti_pos       fff0a193 00002018 00000005 00000000 00000000 0 0000201c 0
sltiu_max      fff0b193 0000201c 00000005 00000000 00000001 0 00002020 0
sll_reg        002091b3 00003000 00000001 00000024 00000010 0 00003004 0
srl_reg        0020d1b3 00003004 80000000 0000003f 00000001 0 00003008 0
slli_imm       00409193 00003008 0000000f 00000000 000000f0 0 0000300c 0
srli_imm       01f0d193 0000300c ffffffff 00000000 00000001 0 00003010 0
beq_taken      00208863 00004000 00000005 00000005 00000000 1 00004010 0
beq_not        00208863 00004004 00000005 00000006 00000000 0 00004008 0
bne_taken_neg  fe209ce3 00004008 00000005 00000006 00000000 1 00004000 0
bne_not        00209863 0000400c 00000005 00000005 00000000 0 00004010 0
blt_taken      0020c863 00004010 ffffffff 00000001 00000000 1 00004020 0
blt_not        0020c863 00004014 00000001 ffffffff 00000000 0 00004018 0
bge_taken_neg  fe20dce3 00004018 00000001 ffffffff 00000000 1 00004010 0
bge_not        0020d863 0000401c ffffffff 00000001 00000000 0 00004020 0
bltu_taken     0020e863 00004020 00000001 ffffffff 00000000 1 00004030 0
bltu_not       0020e863 00004024 ffffffff 00000001 00000000 0 00004028 0
bgeu_taken     0020f863 00004028 ffffffff 00000001 00000000 1 00004038 0
bgeu_not       0020f863 0000402c 00000001 ffffffff 00000000 0 00004030 0
sra_illegal    4020d1b3 00005000 80000000 00000004 00000000 0 00005004 1
srai_illegal   4030d193 00005004 80000000 00000000 00000000 0 00005008 1
opcode_illegal 123451b7 00005008 00000001 00000002 00000000 0 0000500c 1
br_f3_illegal  0020a863 0000500c 00000005 00000005 00000000 0 00005010 1

// ==== files.f ====
hw/exu_pkg.sv
hw/alu.sv
hw/branch_target.sv
hw/exu_decoder.sv
hw/exu_ctrl.sv
hw/exu_top.sv
sim/exu_sva.sv
sim/tb_exu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
FILELIST  := files.f
TOP       := tb_exu_top
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
